// File: ext_mem_defines.svh
`ifndef EXT_MEM_DEFINES_SVH
`define EXT_MEM_DEFINES_SVH

// Native bus widths
`define EXT_MEM_ADDR_W 16
`define EXT_MEM_DATA_W 32

// One strobe bit per data byte
`define EXT_MEM_STRB_W (`EXT_MEM_DATA_W / 8)

// Byte-in-word address bits
`define EXT_MEM_BOFF_W 2

// Word address seen by the caches
`define EXT_MEM_WADDR_W (`EXT_MEM_ADDR_W - `EXT_MEM_BOFF_W)

// Cache geometry, 8 lines of 4 words
`define EXT_MEM_IDX_W 3
`define EXT_MEM_OFF_W 2

`define EXT_MEM_LINES (1 << `EXT_MEM_IDX_W)
`define EXT_MEM_WORDS (1 << `EXT_MEM_OFF_W)

// Whatever is left of the word address is tag
`define EXT_MEM_TAG_W (`EXT_MEM_WADDR_W - `EXT_MEM_IDX_W - `EXT_MEM_OFF_W)

`endif

// File: ext_mem_pkg.sv
`include "ext_mem_defines.svh"

package ext_mem_pkg;

   // Request from a master, a write when any strobe is set
   typedef struct packed {
      logic                       valid;
      logic [`EXT_MEM_ADDR_W-1:0] addr;
      logic [`EXT_MEM_DATA_W-1:0] wdata;
      logic [`EXT_MEM_STRB_W-1:0] wstrb;
   } mem_req_t;

   // Response, ready pulses once per request
   typedef struct packed {
      logic [`EXT_MEM_DATA_W-1:0] rdata;
      logic                       ready;
   } mem_resp_t;

   // Word address split for the line lookup
   typedef struct packed {
      logic [`EXT_MEM_TAG_W-1:0] tag;
      logic [`EXT_MEM_IDX_W-1:0] idx;
      logic [`EXT_MEM_OFF_W-1:0] off;
   } line_addr_t;

   // Same word address, flat for the back end or split for the lookup
   typedef union packed {
      logic [`EXT_MEM_WADDR_W-1:0] flat;
      line_addr_t                  line;
   } cache_addr_u;

   // Cache controller states
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_REFILL,
      ST_WRITE,
      ST_RESPOND
   } cache_state_t;

endpackage

// File: l1_cache.sv
`include "ext_mem_defines.svh"

module l1_cache (
   input  logic                   clk,
   input  logic                   rst,

   // Front end, from the CPU side bus
   input  ext_mem_pkg::mem_req_t  fe_req,
   output ext_mem_pkg::mem_resp_t fe_resp,

   // Back end, towards the merge
   output ext_mem_pkg::mem_req_t  be_req,
   input  ext_mem_pkg::mem_resp_t be_resp
);

   import ext_mem_pkg::*;

   cache_state_t state;
   cache_state_t state_nxt;

   cache_addr_u fe_addr;
   cache_addr_u be_addr;

   // Word being fetched during a refill
   logic [`EXT_MEM_OFF_W-1:0] refill_cnt;

   // Line storage, data indexed by {index, offset}
   logic [`EXT_MEM_DATA_W-1:0] data_mem [`EXT_MEM_LINES*`EXT_MEM_WORDS];
   logic [`EXT_MEM_TAG_W-1:0]  tag_mem [`EXT_MEM_LINES];
   logic [`EXT_MEM_LINES-1:0]  line_valid;

   logic [`EXT_MEM_IDX_W+`EXT_MEM_OFF_W-1:0] word_sel;
   logic [`EXT_MEM_IDX_W+`EXT_MEM_OFF_W-1:0] fill_sel;

   logic is_write;
   logic hit;
   logic refill_last;

   // Drop the byte-in-word bits, the front end works on words
   assign fe_addr.flat = fe_req.addr[`EXT_MEM_ADDR_W-1:`EXT_MEM_BOFF_W];

   assign is_write = |fe_req.wstrb;

   assign hit = line_valid[fe_addr.line.idx] &&
                (tag_mem[fe_addr.line.idx] == fe_addr.line.tag);

   assign word_sel = {fe_addr.line.idx, fe_addr.line.off};
   assign fill_sel = {fe_addr.line.idx, refill_cnt};

   // Last word of the line has arrived
   assign refill_last = (state == ST_REFILL) && be_resp.ready &&
                        (refill_cnt == {`EXT_MEM_OFF_W{1'b1}});

   // Back-end address, refill walks the line in offset order
   always_comb begin
      be_addr.line.tag = fe_addr.line.tag;
      be_addr.line.idx = fe_addr.line.idx;
      if (state == ST_REFILL) begin
         be_addr.line.off = refill_cnt;
      end else begin
         be_addr.line.off = fe_addr.line.off;
      end
   end

   assign be_req.valid = (state == ST_REFILL) || (state == ST_WRITE);
   assign be_req.addr  = {be_addr.flat, {`EXT_MEM_BOFF_W{1'b0}}};
   assign be_req.wdata = fe_req.wdata;
   // Strobes pass unchanged on write-through, zero on refill reads
   assign be_req.wstrb = (state == ST_WRITE) ? fe_req.wstrb : '0;

   // Read hit answers straight from the lookup cycle
   assign fe_resp.ready = (state == ST_RESPOND) ||
                          ((state == ST_LOOKUP) && !is_write && hit);
   assign fe_resp.rdata = data_mem[word_sel];

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (fe_req.valid) begin
               state_nxt = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (is_write) begin
               state_nxt = ST_WRITE;
            end else if (hit) begin
               state_nxt = ST_IDLE;
            end else begin
               state_nxt = ST_REFILL;
            end
         end
         ST_REFILL: begin
            if (refill_last) begin
               state_nxt = ST_RESPOND;
            end
         end
         ST_WRITE: begin
            if (be_resp.ready) begin
               state_nxt = ST_RESPOND;
            end
         end
         ST_RESPOND: begin
            state_nxt = ST_IDLE;
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ST_IDLE;
         refill_cnt <= '0;
         line_valid <= '0;
      end else begin
         state <= state_nxt;

         if (state == ST_LOOKUP) begin
            refill_cnt <= '0;
         end else if ((state == ST_REFILL) && be_resp.ready) begin
            refill_cnt <= refill_cnt + `EXT_MEM_OFF_W'(1);
         end

         // Line is unusable while its words are being replaced
         if ((state == ST_LOOKUP) && !is_write && !hit) begin
            line_valid[fe_addr.line.idx] <= 1'b0;
         end else if (refill_last) begin
            line_valid[fe_addr.line.idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if ((state == ST_REFILL) && be_resp.ready) begin
         data_mem[fill_sel] <= be_resp.rdata;
      end

      if (refill_last) begin
         tag_mem[fe_addr.line.idx] <= fe_addr.line.tag;
      end

      // Write hit, merge the strobed bytes into the line
      if ((state == ST_LOOKUP) && is_write && hit) begin
         for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
            if (fe_req.wstrb[b]) begin
               data_mem[word_sel][8*b +: 8] <= fe_req.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: bus_merge.sv
module bus_merge (
   input  logic                   clk,
   input  logic                   rst,

   // Master 0 has priority when the slave is free
   input  ext_mem_pkg::mem_req_t  m0_req,
   output ext_mem_pkg::mem_resp_t m0_resp,

   input  ext_mem_pkg::mem_req_t  m1_req,
   output ext_mem_pkg::mem_resp_t m1_resp,

   // Shared slave port
   output ext_mem_pkg::mem_req_t  s_req,
   input  ext_mem_pkg::mem_resp_t s_resp
);

   // Grant held until the slave answers
   logic busy;
   // Owner of a held grant, high for master 1
   logic owner;
   // Master routed to the slave this cycle
   logic sel;

   // While free, master 1 only gets the port when master 0 is quiet
   assign sel = busy ? owner : !m0_req.valid;

   assign s_req = sel ? m1_req : m0_req;

   // Data fans out to both, ready goes to the owner only
   assign m0_resp.rdata = s_resp.rdata;
   assign m0_resp.ready = s_resp.ready && !sel;

   assign m1_resp.rdata = s_resp.rdata;
   assign m1_resp.ready = s_resp.ready && sel;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy  <= 1'b0;
         owner <= 1'b0;
      end else if (s_resp.ready) begin
         busy <= 1'b0;
      end else if (!busy && s_req.valid) begin
         busy  <= 1'b1;
         owner <= sel;
      end
   end

endmodule

// File: ext_mem.sv
module ext_mem (
   input  logic                   clk,
   input  logic                   rst,

   // Instruction bus
   input  ext_mem_pkg::mem_req_t  i_req,
   output ext_mem_pkg::mem_resp_t i_resp,

   // Data bus
   input  ext_mem_pkg::mem_req_t  d_req,
   output ext_mem_pkg::mem_resp_t d_resp,

   // Native memory port
   output ext_mem_pkg::mem_req_t  be_req,
   input  ext_mem_pkg::mem_resp_t be_resp
);

   import ext_mem_pkg::*;

   // Cache back ends into the merge
   mem_req_t  icache_be_req;
   mem_resp_t icache_be_resp;
   mem_req_t  dcache_be_req;
   mem_resp_t dcache_be_resp;

   l1_cache icache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (icache_be_req),
      .be_resp (icache_be_resp)
   );

   l1_cache dcache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (dcache_be_req),
      .be_resp (dcache_be_resp)
   );

   // Instruction side is master 0
   bus_merge merge_i_d (
      .clk     (clk),
      .rst     (rst),
      .m0_req  (icache_be_req),
      .m0_resp (icache_be_resp),
      .m1_req  (dcache_be_req),
      .m1_resp (dcache_be_resp),
      .s_req   (be_req),
      .s_resp  (be_resp)
   );

endmodule

// File: ext_mem_assert.sv
`include "ext_mem_defines.svh"

module ext_mem_assert (
   input logic                   clk,
   input logic                   rst,
   input ext_mem_pkg::mem_req_t  i_req,
   input ext_mem_pkg::mem_resp_t i_resp,
   input ext_mem_pkg::mem_req_t  d_req,
   input ext_mem_pkg::mem_resp_t d_resp,
   input ext_mem_pkg::mem_req_t  be_req,
   input ext_mem_pkg::mem_resp_t be_resp
);

   import ext_mem_pkg::*;

   // Name of the running test, written by the testbench
   string test_name = "reset";
   int    fail_cnt  = 0;

   // Memory contents as the data bus should see them
   logic [`EXT_MEM_DATA_W-1:0] shadow [1 << `EXT_MEM_WADDR_W];

   logic [`EXT_MEM_WADDR_W-1:0] i_widx;
   logic [`EXT_MEM_WADDR_W-1:0] d_widx;
   logic [`EXT_MEM_DATA_W-1:0]  i_expect;
   logic [`EXT_MEM_DATA_W-1:0]  d_expect;

   logic [2:0] idle_flags;
   logic [2:0] orphan_ready;
   logic [1:0] fe_ready;
   logic [1:0] fe_ready_q;
   mem_req_t   be_req_q;

   assign i_widx   = i_req.addr[`EXT_MEM_ADDR_W-1:`EXT_MEM_BOFF_W];
   assign d_widx   = d_req.addr[`EXT_MEM_ADDR_W-1:`EXT_MEM_BOFF_W];
   assign i_expect = shadow[i_widx];
   assign d_expect = shadow[d_widx];

   assign idle_flags   = {be_req.valid, i_resp.ready, d_resp.ready};
   assign orphan_ready = {be_resp.ready && !be_req.valid,
                          i_resp.ready && !i_req.valid,
                          d_resp.ready && !d_req.valid};
   assign fe_ready     = {i_resp.ready, d_resp.ready};

   always_ff @(posedge clk) begin
      be_req_q   <= be_req;
      fe_ready_q <= fe_ready;
      if (rst) begin
         // Unwritten word holds its word address XOR A5A5_0000
         for (int w = 0; w < (1 << `EXT_MEM_WADDR_W); w++) begin
            shadow[w[`EXT_MEM_WADDR_W-1:0]] <= w ^ 32'hA5A5_0000;
         end
      end else if (d_resp.ready && (d_req.wstrb != '0)) begin
         for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
            if (d_req.wstrb[b]) begin
               shadow[d_widx][8*b +: 8] <= d_req.wdata[8*b +: 8];
            end
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk) rst |=> (idle_flags == 3'b000))
      else begin
         $error("Mismatch %s: expected %b, actual %b", test_name, 3'b000, idle_flags);
         fail_cnt = fail_cnt + 1;
      end

   a_i_rdata: assert property (@(posedge clk) disable iff (rst)
      i_resp.ready |-> (i_resp.rdata == i_expect))
      else begin
         $error("Mismatch %s: expected %h, actual %h", test_name, i_expect, i_resp.rdata);
         fail_cnt = fail_cnt + 1;
      end

   a_d_rdata: assert property (@(posedge clk) disable iff (rst)
      (d_resp.ready && (d_req.wstrb == '0)) |-> (d_resp.rdata == d_expect))
      else begin
         $error("Mismatch %s: expected %h, actual %h", test_name, d_expect, d_resp.rdata);
         fail_cnt = fail_cnt + 1;
      end

   // Back-end request may only change after its ready
   a_be_steady: assert property (@(posedge clk) disable iff (rst)
      (be_req.valid && !be_resp.ready) |=> (be_req == be_req_q))
      else begin
         $error("Mismatch %s: expected %h, actual %h", test_name, be_req_q, be_req);
         fail_cnt = fail_cnt + 1;
      end

   a_ready_has_valid: assert property (@(posedge clk) disable iff (rst)
      orphan_ready == 3'b000)
      else begin
         $error("Mismatch %s: expected %b, actual %b", test_name, 3'b000, orphan_ready);
         fail_cnt = fail_cnt + 1;
      end

   // Front-end ready never lasts two cycles
   a_ready_single: assert property (@(posedge clk) disable iff (rst)
      (fe_ready & fe_ready_q) == 2'b00)
      else begin
         $error("Mismatch %s: expected %b, actual %b", test_name, 2'b00,
                fe_ready & fe_ready_q);
         fail_cnt = fail_cnt + 1;
      end

endmodule

bind ext_mem ext_mem_assert u_chk (
   .clk     (clk),
   .rst     (rst),
   .i_req   (i_req),
   .i_resp  (i_resp),
   .d_req   (d_req),
   .d_resp  (d_resp),
   .be_req  (be_req),
   .be_resp (be_resp)
);

// File: tb_clock_gen.sv
module tb_clock_gen (
   output logic clk,
   output logic rst
);

   // 20 unit period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Released just after the 16th rising edge
   initial begin
      rst = 1'b1;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
   end

endmodule

// File: ext_mem_tb.sv
`include "ext_mem_defines.svh"

module ext_mem_tb;

   import ext_mem_pkg::*;

   localparam int SEED = 39298;
   // 16 fetches, 8 data reads, two write and read pairs, 4 paired misses
   localparam int N_REQUESTS = 36;
   localparam int TIMEOUT_CYCLES = 40 * N_REQUESTS;
   localparam int N_WORDS = 1 << `EXT_MEM_WADDR_W;

   logic      clk;
   logic      rst;
   mem_req_t  i_req;
   mem_resp_t i_resp;
   mem_req_t  d_req;
   mem_resp_t d_resp;
   mem_req_t  be_req;
   mem_resp_t be_resp;

   logic [`EXT_MEM_DATA_W-1:0] mem [N_WORDS];

   int cycle_cnt;
   int tests_run;
   int tests_failed;
   int fails_at_start;

   tb_clock_gen clock_gen (
      .clk (clk),
      .rst (rst)
   );

   ext_mem i_dut (
      .clk     (clk),
      .rst     (rst),
      .i_req   (i_req),
      .i_resp  (i_resp),
      .d_req   (d_req),
      .d_resp  (d_resp),
      .be_req  (be_req),
      .be_resp (be_resp)
   );

   // Back-end memory answering each request after 1 to 3 cycles
   initial begin : mem_model
      mem_req_t                    cur;
      int                          wait_cnt;
      logic                        was_ready;
      logic [`EXT_MEM_WADDR_W-1:0] widx;
      be_resp  = '0;
      wait_cnt = 0;
      for (int w = 0; w < N_WORDS; w++) begin
         mem[w[`EXT_MEM_WADDR_W-1:0]] = w ^ 32'hA5A5_0000;
      end
      forever begin
         @(negedge clk);
         if (wait_cnt == 0) begin
            cur = be_req;
         end
         @(posedge clk);
         #2;
         was_ready     = be_resp.ready;
         be_resp.ready = 1'b0;
         // A request seen with its own ready is already done
         if (rst) begin
            wait_cnt = 0;
         end else if ((wait_cnt == 0) && cur.valid && !was_ready) begin
            wait_cnt = 1 + int'($urandom % 3);
         end
         if (wait_cnt != 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
               widx = cur.addr[`EXT_MEM_ADDR_W-1:`EXT_MEM_BOFF_W];
               for (int b = 0; b < `EXT_MEM_STRB_W; b++) begin
                  if (cur.wstrb[b]) begin
                     mem[widx][8*b +: 8] = cur.wdata[8*b +: 8];
                  end
               end
               be_resp.rdata = mem[widx];
               be_resp.ready = 1'b1;
            end
         end
      end
   end

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic fetch_instr(input logic [`EXT_MEM_ADDR_W-1:0] addr);
      i_req = '{valid: 1'b1, addr: addr, wdata: '0, wstrb: '0};
      @(negedge clk);
      while (!i_resp.ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      i_req.valid = 1'b0;
   endtask

   task automatic access_data(input logic [`EXT_MEM_ADDR_W-1:0] addr,
                              input logic [`EXT_MEM_DATA_W-1:0] wdata,
                              input logic [`EXT_MEM_STRB_W-1:0] wstrb);
      d_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      @(negedge clk);
      while (!d_resp.ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #2;
      d_req.valid = 1'b0;
   endtask

   task automatic begin_test(input string name);
      i_dut.u_chk.test_name = name;
      fails_at_start = i_dut.u_chk.fail_cnt;
   endtask

   task automatic end_test();
      int fails;
      // One more edge for the checks that look a cycle ahead
      @(posedge clk);
      #2;
      fails = i_dut.u_chk.fail_cnt - fails_at_start;
      tests_run++;
      if (fails == 0) begin
         $display("Test %s finished cleanly", i_dut.u_chk.test_name);
      end else begin
         tests_failed++;
         $display("Test %s finished with %0d failed assertions",
                  i_dut.u_chk.test_name, fails);
      end
   endtask

   initial begin : stimulus
      logic [`EXT_MEM_DATA_W-1:0] wdata;
      void'($urandom(SEED));
      i_req        = '0;
      d_req        = '0;
      tests_run    = 0;
      tests_failed = 0;
      @(negedge rst);
      @(posedge clk);
      #2;

      // Two full lines, then the same words again as hits
      begin_test("ifetch_lines");
      for (int pass = 0; pass < 2; pass++) begin
         for (int w = 0; w < 8; w++) begin
            fetch_instr(16'h0100 + 16'(4 * w));
         end
      end
      end_test();

      begin_test("dread_miss_hit");
      for (int pass = 0; pass < 2; pass++) begin
         for (int w = 0; w < 4; w++) begin
            access_data(16'h0400 + 16'(4 * w), '0, '0);
         end
      end
      end_test();

      // Line of 0x0404 is still in the data cache
      begin_test("dwrite_present");
      wdata = $urandom;
      access_data(16'h0404, wdata, 4'b0101);
      access_data(16'h0404, '0, '0);
      end_test();

      // Same index as 0x0400 but another tag
      begin_test("dwrite_absent");
      wdata = $urandom;
      access_data(16'h0800, wdata, 4'b1100);
      access_data(16'h0800, '0, '0);
      end_test();

      // Later rounds start the fetch while the data refill already holds the port
      begin_test("dual_miss");
      for (int k = 0; k < 4; k++) begin
         fork
            begin
               idle_cycles(k);
               fetch_instr(16'h0200 + 16'(16 * k));
            end
            access_data(16'h0600 + 16'(16 * k), '0, '0);
         join
      end
      end_test();

      $display("Summary: %0d tests, %0d clean, %0d failed, %0d assertion failures",
               tests_run, tests_run - tests_failed, tests_failed, i_dut.u_chk.fail_cnt);
      if ((tests_failed == 0) && (i_dut.u_chk.fail_cnt == 0)) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: tb.f
+incdir+.
ext_mem_pkg.sv
l1_cache.sv
bus_merge.sv
ext_mem.sv
ext_mem_assert.sv
tb_clock_gen.sv
ext_mem_tb.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --assert -f tb.f --top-module ext_mem_tb -o ext_mem_sim

out=$(./obj_dir/ext_mem_sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
